/* source/dbg_bus_config.svh */
/*
 * Build-time sizing for the debug bus bridge project.
 * Included by the RAM slave and by the testbench. Override a value
 * by defining it before this header is seen.
 */

`ifndef DBG_BUS_CONFIG_SVH
`define DBG_BUS_CONFIG_SVH

// RAM depth in 32-bit words
// Byte addresses at or above 4x this value answer with err
`define DBG_RAM_WORDS 256

// Bus cycles between stb and ack, 0 gives ack in the stb cycle
`define DBG_RAM_WAIT 2

`endif

/* source/dbg_bus_pkg.sv */
/*
 * Shared types for the debug bus bridge: data, address and byte-enable
 * types plus the command opcode, access size and bus FSM encodings.
 * Referenced by scoped name from every block and the testbench.
 */

`default_nettype none

package dbg_bus_pkg;

  // Bus data word and byte address
  typedef logic [31:0] dbg_word_t;
  typedef logic [31:0] dbg_addr_t;

  // Byte enables, bit 3 is the lowest-addressed byte (big-endian)
  typedef logic [3:0] dbg_sel_t;

  // Debug command opcodes
  typedef enum logic [1:0] {
    OP_NOP      = 2'd0,
    OP_SET_ADDR = 2'd1,
    OP_WRITE    = 2'd2,
    OP_READ     = 2'd3
  } dbg_op_e;

  // Access size in bytes, value doubles as the address step
  typedef enum logic [2:0] {
    SZ_BYTE = 3'd1,
    SZ_HALF = 3'd2,
    SZ_WORD = 3'd4
  } dbg_size_e;

  // Single-access bus state machine
  typedef enum logic {
    ST_IDLE     = 1'b0,
    ST_TRANSFER = 1'b1
  } dbg_fsm_e;

endpackage

`default_nettype wire

/* source/dbg_xfer_if.sv */
/*
 * One debug transfer between the command unit and the bridge.
 * Request is qualified by a one-cycle strobe while rdy is high;
 * rdata and err are valid once rdy returns high.
 */

`timescale 1ns/10ps
`default_nettype none

interface dbg_xfer_if;

  // Request side, test clock domain
  dbg_bus_pkg::dbg_addr_t addr;
  dbg_bus_pkg::dbg_word_t wdata;
  dbg_bus_pkg::dbg_size_e size;
  logic                   rd_wrn;
  logic                   strobe;

  // Completion side
  logic                   rdy;
  dbg_bus_pkg::dbg_word_t rdata;
  logic                   err;

  modport master (
    output addr, wdata, size, rd_wrn, strobe,
    input  rdy, rdata, err
  );

  modport slave (
    input  addr, wdata, size, rd_wrn, strobe,
    output rdy, rdata, err
  );

endinterface

`default_nettype wire

/* source/dbg_bus_if.sv */
/*
 * Wishbone-style single-access bus between the bridge and the RAM.
 * cyc and stb hold until the slave answers with ack or err for one
 * cycle. Bursts are not supported.
 */

`timescale 1ns/10ps
`default_nettype none

interface dbg_bus_if;

  // Master outputs
  dbg_bus_pkg::dbg_addr_t adr;
  dbg_bus_pkg::dbg_word_t dat_w;
  dbg_bus_pkg::dbg_sel_t  sel;
  logic                   we;
  logic                   cyc;
  logic                   stb;

  // Slave outputs
  dbg_bus_pkg::dbg_word_t dat_r;
  logic                   ack;
  logic                   err;

  modport master (
    output adr, dat_w, sel, we, cyc, stb,
    input  dat_r, ack, err
  );

  modport slave (
    input  adr, dat_w, sel, we, cyc, stb,
    output dat_r, ack, err
  );

endinterface

`default_nettype wire

/* source/dbg_cmd_unit.sv */
/*
 * Debug command decoder in the test clock domain. Keeps the current
 * address, launches reads and writes on the transfer interface and
 * returns a one-cycle response, stepping the address on success.
 */

`timescale 1ns/10ps
`default_nettype none

module dbg_cmd_unit (
  input  wire                         tck_i,
  input  wire                         rst_i,
  input  wire                         cmd_stb_i,
  input  wire dbg_bus_pkg::dbg_op_e   cmd_op_i,
  input  wire dbg_bus_pkg::dbg_size_e cmd_size_i,
  input  wire dbg_bus_pkg::dbg_addr_t cmd_addr_i,
  input  wire dbg_bus_pkg::dbg_word_t cmd_data_i,
  output logic                        busy_o,
  output logic                        rsp_valid_o,
  output dbg_bus_pkg::dbg_word_t      rsp_data_o,
  output logic                        rsp_err_o,
  dbg_xfer_if.master                  xfer
);

  dbg_bus_pkg::dbg_addr_t addr_q;
  dbg_bus_pkg::dbg_word_t wdata_q;
  dbg_bus_pkg::dbg_size_e size_q;
  logic                   rd_q;
  logic                   strobe_q;
  logic                   rdy_q;
  logic                   accept;
  logic                   is_xfer;
  logic                   done;

  // Commands are dropped while a transfer is outstanding
  assign accept  = cmd_stb_i & ~busy_o;
  assign is_xfer = (cmd_op_i == dbg_bus_pkg::OP_READ) || (cmd_op_i == dbg_bus_pkg::OP_WRITE);
  // Completion is the rising edge of rdy
  assign done    = busy_o & xfer.rdy & ~rdy_q;

  // Request fields held for the bridge
  always_ff @(posedge tck_i) begin
    if (accept && is_xfer) begin
      wdata_q <= cmd_data_i;
      size_q  <= cmd_size_i;
      rd_q    <= (cmd_op_i == dbg_bus_pkg::OP_READ);
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      addr_q      <= '0;
      strobe_q    <= 1'b0;
      busy_o      <= 1'b0;
      rdy_q       <= 1'b1;
      rsp_valid_o <= 1'b0;
      rsp_data_o  <= '0;
      rsp_err_o   <= 1'b0;
    end else begin
      strobe_q    <= 1'b0;
      rsp_valid_o <= 1'b0;
      rdy_q       <= xfer.rdy;
      if (accept && cmd_op_i == dbg_bus_pkg::OP_SET_ADDR) begin
        addr_q <= cmd_addr_i;
      end
      // Launch, busy shows up on the next edge
      if (accept && is_xfer) begin
        busy_o   <= 1'b1;
        strobe_q <= 1'b1;
      end
      if (done) begin
        busy_o      <= 1'b0;
        rsp_valid_o <= 1'b1;
        rsp_data_o  <= rd_q ? xfer.rdata : '0;
        rsp_err_o   <= xfer.err;
        // Failed accesses keep the address for a retry
        if (!xfer.err) begin
          addr_q <= addr_q + dbg_bus_pkg::dbg_addr_t'(size_q);
        end
      end
    end
  end

  assign xfer.addr   = addr_q;
  assign xfer.wdata  = wdata_q;
  assign xfer.size   = size_q;
  assign xfer.rd_wrn = rd_q;
  assign xfer.strobe = strobe_q;

  // Bridge must be idle whenever a request is launched
  a_strobe_rdy : assert property (@(posedge tck_i) disable iff (rst_i)
    xfer.strobe |-> xfer.rdy)
    else $error("strobe issued while bridge not ready");

endmodule

`default_nettype wire

/* source/dbg_bus_bridge.sv */
/*
 * Clock-crossing bus master. Latches one debug transfer in the test
 * clock domain, hands it over by toggle synchronizers and runs a
 * single Wishbone-style access on the bus clock. Big-endian lanes.
 */

`timescale 1ns/10ps
`default_nettype none

module dbg_bus_bridge (
  input  wire        tck_i,
  input  wire        ahb3_clk_i,
  input  wire        rst_i,
  dbg_xfer_if.slave  xfer,
  dbg_bus_if.master  bus
);

  // Test clock side
  dbg_bus_pkg::dbg_sel_t  be_dec;
  dbg_bus_pkg::dbg_word_t wdata_steer;
  dbg_bus_pkg::dbg_sel_t  sel_q;
  dbg_bus_pkg::dbg_addr_t addr_q;
  dbg_bus_pkg::dbg_word_t wdata_q;
  logic                   we_q;
  logic                   accept;
  logic                   start_tgl;
  logic                   rdy_q;
  logic                   rdy_ff1;
  logic                   rdy_ff2;
  logic                   rdy_ff2q;

  // Bus clock side
  logic                   str_ff1;
  logic                   str_ff2;
  logic                   str_ff2q;
  logic                   start_seen;
  logic                   resp;
  logic                   done_tgl;
  logic                   err_q;
  dbg_bus_pkg::dbg_word_t rdata_steer;
  dbg_bus_pkg::dbg_word_t rdata_q;
  dbg_bus_pkg::dbg_fsm_e  state_q;
  dbg_bus_pkg::dbg_fsm_e  state_d;

  ////////////////////////////////////////////////////////////
  // Test clock domain
  ////////////////////////////////////////////////////////////

  assign accept = xfer.strobe & rdy_q;

  // Size and low address bits to byte lanes, lowest address on bits 31:24
  always_comb begin
    case (xfer.size)
      dbg_bus_pkg::SZ_BYTE: begin
        case (xfer.addr[1:0])
          2'b00:   be_dec = 4'b1000;
          2'b01:   be_dec = 4'b0100;
          2'b10:   be_dec = 4'b0010;
          default: be_dec = 4'b0001;
        endcase
      end
      dbg_bus_pkg::SZ_HALF: be_dec = xfer.addr[1] ? 4'b0011 : 4'b1100;
      default:              be_dec = 4'b1111;
    endcase
  end

  // Short write data arrives in the upper bits, move it to its lanes
  always_comb begin
    case (be_dec)
      4'b0011: wdata_steer = {16'h0, xfer.wdata[31:16]};
      4'b0001: wdata_steer = {24'h0, xfer.wdata[31:24]};
      4'b0010: wdata_steer = {16'h0, xfer.wdata[31:24], 8'h0};
      4'b0100: wdata_steer = {8'h0, xfer.wdata[31:24], 16'h0};
      4'b1000: wdata_steer = {xfer.wdata[31:24], 24'h0};
      default: wdata_steer = xfer.wdata;
    endcase
  end

  // Request held stable for the whole bus access
  always_ff @(posedge tck_i) begin
    if (accept) begin
      sel_q   <= be_dec;
      addr_q  <= xfer.addr;
      wdata_q <= wdata_steer;
      we_q    <= ~xfer.rd_wrn;
    end
  end

  // Start toggle and ready handshake
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      start_tgl <= 1'b0;
      rdy_ff1   <= 1'b0;
      rdy_ff2   <= 1'b0;
      rdy_ff2q  <= 1'b0;
      rdy_q     <= 1'b1;
    end else begin
      rdy_ff1  <= done_tgl;
      rdy_ff2  <= rdy_ff1;
      rdy_ff2q <= rdy_ff2;
      if (accept) begin
        start_tgl <= ~start_tgl;
        rdy_q     <= 1'b0;
      end else if (rdy_ff2 != rdy_ff2q) begin
        rdy_q <= 1'b1;
      end
    end
  end

  assign xfer.rdy   = rdy_q;
  assign xfer.rdata = rdata_q;
  assign xfer.err   = err_q;

  ////////////////////////////////////////////////////////////
  // Bus clock domain
  ////////////////////////////////////////////////////////////

  always_ff @(posedge ahb3_clk_i or posedge rst_i) begin
    if (rst_i) begin
      str_ff1  <= 1'b0;
      str_ff2  <= 1'b0;
      str_ff2q <= 1'b0;
    end else begin
      str_ff1  <= start_tgl;
      str_ff2  <= str_ff1;
      str_ff2q <= str_ff2;
    end
  end

  assign start_seen = str_ff2 ^ str_ff2q;
  assign resp       = (state_q == dbg_bus_pkg::ST_TRANSFER) & (bus.ack | bus.err);

  always_comb begin
    state_d = state_q;
    case (state_q)
      dbg_bus_pkg::ST_IDLE:     if (start_seen) state_d = dbg_bus_pkg::ST_TRANSFER;
      dbg_bus_pkg::ST_TRANSFER: if (bus.ack || bus.err) state_d = dbg_bus_pkg::ST_IDLE;
      default:                  state_d = dbg_bus_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge ahb3_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= dbg_bus_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Access is active for the whole transfer state
  assign bus.cyc   = (state_q == dbg_bus_pkg::ST_TRANSFER);
  assign bus.stb   = (state_q == dbg_bus_pkg::ST_TRANSFER);
  assign bus.adr   = addr_q;
  assign bus.dat_w = wdata_q;
  assign bus.sel   = sel_q;
  assign bus.we    = we_q;

  // Read lanes back to the low end, zero filled
  always_comb begin
    case (sel_q)
      4'b0011: rdata_steer = {16'h0, bus.dat_r[15:0]};
      4'b1100: rdata_steer = {16'h0, bus.dat_r[31:16]};
      4'b0001: rdata_steer = {24'h0, bus.dat_r[7:0]};
      4'b0010: rdata_steer = {24'h0, bus.dat_r[15:8]};
      4'b0100: rdata_steer = {24'h0, bus.dat_r[23:16]};
      4'b1000: rdata_steer = {24'h0, bus.dat_r[31:24]};
      default: rdata_steer = bus.dat_r;
    endcase
  end

  // Errored accesses report zero data
  always_ff @(posedge ahb3_clk_i) begin
    if (resp) begin
      rdata_q <= bus.ack ? rdata_steer : '0;
    end
  end

  always_ff @(posedge ahb3_clk_i or posedge rst_i) begin
    if (rst_i) begin
      err_q    <= 1'b0;
      done_tgl <= 1'b0;
    end else if (resp) begin
      err_q    <= bus.err;
      done_tgl <= ~done_tgl;
    end
  end

  // Access held until answered, test clock side not ready meanwhile
  a_hold_req : assert property (@(posedge ahb3_clk_i) disable iff (rst_i)
    (bus.cyc && bus.stb && !(bus.ack || bus.err)) |=> (bus.cyc && bus.stb && !xfer.rdy))
    else $error("access dropped or ready raised before the slave answered");

  a_ack_err : assert property (@(posedge ahb3_clk_i) disable iff (rst_i)
    !(bus.ack && bus.err))
    else $error("ack and err raised together");

endmodule

`default_nettype wire

/* source/dbg_bus_ram.sv */
/*
 * On-chip RAM bus slave with byte enables. Acknowledges after a fixed
 * number of wait cycles; addresses past the end answer with err and
 * leave the contents alone.
 */

`timescale 1ns/10ps
`default_nettype none

`include "dbg_bus_config.svh"

module dbg_bus_ram (
  input  wire       ahb3_clk_i,
  input  wire       rst_i,
  dbg_bus_if.slave  bus
);

  localparam int unsigned IDX_W = $clog2(`DBG_RAM_WORDS);
  localparam int unsigned CNT_W = $clog2(`DBG_RAM_WAIT + 2);
  localparam logic [CNT_W-1:0] WAIT_CNT = CNT_W'(`DBG_RAM_WAIT);

  dbg_bus_pkg::dbg_word_t mem [`DBG_RAM_WORDS];
  logic [IDX_W-1:0]       idx;
  logic [CNT_W-1:0]       cnt_q;
  logic                   in_range;
  logic                   resp;

  assign idx      = bus.adr[IDX_W+1:2];
  assign in_range = bus.adr < dbg_bus_pkg::dbg_addr_t'(4 * `DBG_RAM_WORDS);
  // Answer once the wait count is reached, same cycle for zero wait
  assign resp     = bus.cyc & bus.stb & (cnt_q == WAIT_CNT);
  assign bus.ack  = resp & in_range;
  assign bus.err  = resp & ~in_range;
  assign bus.dat_r = mem[idx];

  // Wait counter, cleared by the answer
  always_ff @(posedge ahb3_clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (resp) begin
      cnt_q <= '0;
    end else if (bus.cyc && bus.stb) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Only enabled lanes are written
  always_ff @(posedge ahb3_clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < `DBG_RAM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (bus.ack && bus.we) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.sel[b]) begin
          mem[idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
        end
      end
    end
  end

  // Master must hold the request while the slave is counting
  a_req_stable : assert property (@(posedge ahb3_clk_i) disable iff (rst_i)
    (bus.cyc && bus.stb && !bus.ack && !bus.err) |=>
      ($stable(bus.adr) && $stable(bus.we) && $stable(bus.sel) && $stable(bus.dat_w)))
    else $error("bus request changed during wait states");

endmodule

`default_nettype wire

/* source/dbg_bus_top.sv */
/*
 * Debug bus bridge top level. Command unit on the test clock, bridge
 * across both clocks and RAM slave on the bus clock, joined by the
 * transfer and bus interfaces.
 */

`timescale 1ns/10ps
`default_nettype none

module dbg_bus_top (
  input  wire                         tck_i,
  input  wire                         ahb3_clk_i,
  input  wire                         rst_i,
  input  wire                         cmd_stb_i,
  input  wire dbg_bus_pkg::dbg_op_e   cmd_op_i,
  input  wire dbg_bus_pkg::dbg_size_e cmd_size_i,
  input  wire dbg_bus_pkg::dbg_addr_t cmd_addr_i,
  input  wire dbg_bus_pkg::dbg_word_t cmd_data_i,
  output logic                        busy_o,
  output logic                        rsp_valid_o,
  output dbg_bus_pkg::dbg_word_t      rsp_data_o,
  output logic                        rsp_err_o
);

  // Command unit to bridge, and bridge to RAM
  dbg_xfer_if xfer_if ();
  dbg_bus_if  bus_if ();

  dbg_cmd_unit i_cmd (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .cmd_stb_i   (cmd_stb_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_size_i  (cmd_size_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_data_i  (cmd_data_i),
    .busy_o      (busy_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_err_o   (rsp_err_o),
    .xfer        (xfer_if.master)
  );

  dbg_bus_bridge i_bridge (
    .tck_i      (tck_i),
    .ahb3_clk_i (ahb3_clk_i),
    .rst_i      (rst_i),
    .xfer       (xfer_if.slave),
    .bus        (bus_if.master)
  );

  dbg_bus_ram i_ram (
    .ahb3_clk_i (ahb3_clk_i),
    .rst_i      (rst_i),
    .bus        (bus_if.slave)
  );

endmodule

`default_nettype wire

/* bench/tb_dbg_bus_top.sv */
/*
 * Testbench for the debug bus bridge top level. Replays the commands
 * of bench/tb_input.txt on the test clock and compares every response
 * with the expected data and error flag from the same file.
 */

`timescale 1ns/10ps
`default_nettype none

`include "dbg_bus_config.svh"

module tb_dbg_bus_top;

  // Bound for every wait loop, in test clock cycles
  localparam int DBG_TIMEOUT = 200;

  logic                   tck_i;
  logic                   ahb3_clk_i;
  logic                   rst_i;
  logic                   cmd_stb_i;
  dbg_bus_pkg::dbg_op_e   cmd_op_i;
  dbg_bus_pkg::dbg_size_e cmd_size_i;
  dbg_bus_pkg::dbg_addr_t cmd_addr_i;
  dbg_bus_pkg::dbg_word_t cmd_data_i;
  logic                   busy_o;
  logic                   rsp_valid_o;
  dbg_bus_pkg::dbg_word_t rsp_data_o;
  logic                   rsp_err_o;

  int                     cmd_count;
  // Expected address register of the command unit
  dbg_bus_pkg::dbg_addr_t model_addr;

  dbg_bus_top i_dut (
    .tck_i       (tck_i),
    .ahb3_clk_i  (ahb3_clk_i),
    .rst_i       (rst_i),
    .cmd_stb_i   (cmd_stb_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_size_i  (cmd_size_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_data_i  (cmd_data_i),
    .busy_o      (busy_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_err_o   (rsp_err_o)
  );

  ////////////////////////////////////////////////////////////
  // Clocks, unrelated periods of 100 ns and 70 ns
  ////////////////////////////////////////////////////////////

  initial tck_i = 1'b0;
  always #50 tck_i = ~tck_i;

  initial ahb3_clk_i = 1'b0;
  always #35 ahb3_clk_i = ~ahb3_clk_i;

  ////////////////////////////////////////////////////////////
  // Compare tasks and waits
  ////////////////////////////////////////////////////////////

  task automatic check_data(input dbg_bus_pkg::dbg_word_t got,
                            input dbg_bus_pkg::dbg_word_t exp,
                            input string what);
    if (got !== exp) begin
      $display("Fail at %0t: %s data %h, expected %h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t: %s flag %b, expected %b", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out after %0d test clock cycles waiting for %s", DBG_TIMEOUT, what);
    $display("CHECKS FAILED");
    $fatal(1, "wait loop expired");
  endtask

  // Both waits sample on the falling edge, away from the DUT's edge
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy_o && cycles < DBG_TIMEOUT) begin
      @(negedge tck_i);
      cycles++;
    end
    if (busy_o) begin
      report_timeout("busy_o to fall");
    end
  endtask

  task automatic wait_response();
    int cycles;
    cycles = 0;
    while (!rsp_valid_o && cycles < DBG_TIMEOUT) begin
      @(negedge tck_i);
      cycles++;
    end
    if (!rsp_valid_o) begin
      report_timeout("rsp_valid_o");
    end
  endtask

  // One line of the data file; poke adds an inverted-data write while busy
  task automatic run_cmd(input logic [31:0] f_op, input logic [31:0] f_size,
                         input logic [31:0] f_addr, input logic [31:0] f_data,
                         input logic [31:0] f_exp, input logic [31:0] f_err,
                         input logic [31:0] f_poke);
    logic  range_err;
    string what;
    what = $sformatf("command %0d", cmd_count);
    range_err = (model_addr >= dbg_bus_pkg::dbg_addr_t'(4 * `DBG_RAM_WORDS));
    wait_idle();
    cmd_stb_i  = 1'b1;
    cmd_op_i   = dbg_bus_pkg::dbg_op_e'(f_op[1:0]);
    cmd_size_i = dbg_bus_pkg::dbg_size_e'(f_size[2:0]);
    cmd_addr_i = f_addr;
    cmd_data_i = f_data;
    @(negedge tck_i);
    if (f_op[1:0] == 2'd1) begin
      // Set-address never goes busy and gives no response
      cmd_stb_i = 1'b0;
      cmd_op_i  = dbg_bus_pkg::OP_NOP;
      check_err(busy_o, 1'b0, {what, " busy_o after set-address"});
      model_addr = f_addr;
    end else begin
      check_err(busy_o, 1'b1, {what, " busy_o after launch"});
      if (f_poke[0]) begin
        // Held strobe now lands while busy, must be dropped
        cmd_op_i   = dbg_bus_pkg::OP_WRITE;
        cmd_size_i = dbg_bus_pkg::SZ_WORD;
        cmd_data_i = ~f_data;
        @(negedge tck_i);
      end
      cmd_stb_i = 1'b0;
      cmd_op_i  = dbg_bus_pkg::OP_NOP;
      wait_response();
      check_data(rsp_data_o, f_exp, what);
      check_err(rsp_err_o, f_err[0], {what, " rsp_err_o"});
      check_err(rsp_err_o, range_err, {what, " rsp_err_o against RAM range"});
      check_err(busy_o, 1'b0, {what, " busy_o with response"});
      if (!range_err) begin
        model_addr = model_addr + f_size;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_size;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_exp;
    logic [31:0] f_err;
    logic [31:0] f_poke;
    cmd_count   = 0;
    model_addr  = '0;
    rst_i       = 1'b1;
    cmd_stb_i   = 1'b0;
    cmd_op_i    = dbg_bus_pkg::OP_NOP;
    cmd_size_i  = dbg_bus_pkg::SZ_WORD;
    cmd_addr_i  = '0;
    cmd_data_i  = '0;
    fd = $fopen("bench/tb_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open bench/tb_input.txt for reading");
      $display("CHECKS FAILED");
      $fatal(1, "stimulus file missing");
    end
    repeat (10) @(posedge tck_i);
    @(negedge tck_i);
    rst_i = 1'b0;
    @(negedge tck_i);
    // Lines that do not hold seven hex fields are comments
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && $sscanf(line, "%h %h %h %h %h %h %h", f_op, f_size, f_addr,
                           f_data, f_exp, f_err, f_poke) == 7) begin
        run_cmd(f_op, f_size, f_addr, f_data, f_exp, f_err, f_poke);
        cmd_count++;
      end
    end
    $fclose(fd);
    wait_idle();
    if (cmd_count > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
source/dbg_bus_pkg.sv
source/dbg_xfer_if.sv
source/dbg_bus_if.sv
source/dbg_cmd_unit.sv
source/dbg_bus_bridge.sv
source/dbg_bus_ram.sv
source/dbg_bus_top.sv
bench/tb_dbg_bus_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the debug bus bridge testbench with Verilator and run it
# The exit status comes from a search of sim.log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_dbg_bus_top \
  -o tb_dbg_bus_top > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_dbg_bus_top > sim.log 2>&1
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log && echo "Simulation passed" ||
  { echo "No result found in sim.log"; exit 1; }
exit 0

/* bench/tb_input.txt */
# Hex columns: op(1 set-addr, 2 write, 3 read) size(1,2,4) addr data exp_data exp_err poke
# Short write data sits in the upper bits; poke=1 adds a write of ~data while busy
1 4 00000010 00000000 00000000 0 0
2 4 00000000 deadbeef 00000000 0 0
1 4 00000010 00000000 00000000 0 0
3 4 00000000 00000000 deadbeef 0 0
3 4 00000000 00000000 00000000 0 0
# Byte writes, then word and byte reads
1 1 00000020 00000000 00000000 0 0
2 1 00000000 11000000 00000000 0 0
2 1 00000000 22000000 00000000 0 0
2 1 00000000 33000000 00000000 0 0
2 1 00000000 44000000 00000000 0 0
1 4 00000020 00000000 00000000 0 0
3 4 00000000 00000000 11223344 0 0
1 1 00000022 00000000 00000000 0 0
3 1 00000000 00000000 00000033 0 0
3 1 00000000 00000000 00000044 0 0
# Halfwords at offsets 0 and 2
1 4 00000030 00000000 00000000 0 0
2 4 00000000 a1b2c3d4 00000000 0 0
1 2 00000032 00000000 00000000 0 0
2 2 00000000 55660000 00000000 0 0
1 4 00000030 00000000 00000000 0 0
3 4 00000000 00000000 a1b25566 0 0
1 2 00000030 00000000 00000000 0 0
2 2 00000000 77880000 00000000 0 0
1 2 00000030 00000000 00000000 0 0
3 2 00000000 00000000 00007788 0 0
3 2 00000000 00000000 00005566 0 0
# Auto-increment by byte and by halfword
1 1 00000020 00000000 00000000 0 0
3 1 00000000 00000000 00000011 0 0
3 1 00000000 00000000 00000022 0 0
3 1 00000000 00000000 00000033 0 0
3 1 00000000 00000000 00000044 0 0
1 2 00000020 00000000 00000000 0 0
3 2 00000000 00000000 00001122 0 0
3 2 00000000 00000000 00003344 0 0
# Last word, then past the end of the RAM
1 4 000003fc 00000000 00000000 0 0
2 4 00000000 0badf00d 00000000 0 0
2 4 00000000 12345678 00000000 1 0
3 4 00000000 00000000 00000000 1 0
3 4 00000000 00000000 00000000 1 0
1 4 000003fc 00000000 00000000 0 0
3 4 00000000 00000000 0badf00d 0 0
1 4 00000000 00000000 00000000 0 0
3 4 00000000 00000000 00000000 0 0
# Commands strobed while busy are dropped
1 4 00000040 00000000 00000000 0 0
2 4 00000000 01020304 00000000 0 0
1 4 00000040 00000000 00000000 0 0
3 4 00000000 00000000 01020304 0 1
2 4 00000000 0a0b0c0d 00000000 0 1
1 4 00000040 00000000 00000000 0 0
3 4 00000000 00000000 01020304 0 0
3 4 00000000 00000000 0a0b0c0d 0 0
